/* bench/byte_engine_props.sv */
// Result queue assertions on credit use, FIFO fill and credit return timing
`timescale 1ns/1ps

module byte_engine_props #(
    parameter int IN_CREDITS = 4,
    parameter int FILL_W     = 3,
    parameter int CNT_W      = 3
) (
    input logic              clk,
    input logic              rst,
    input logic              res_valid,
    input logic              in_credit,
    input logic [FILL_W-1:0] fill,
    input logic [CNT_W-1:0]  out_cnt
);

    a_res_needs_credit: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> $past(out_cnt) != '0)
        else $error("res_valid raised while the output credit counter was zero");

    a_fill_bound: assert property (@(posedge clk) disable iff (rst)
        fill <= FILL_W'(IN_CREDITS))
        else $error("result FIFO holds more entries than its depth");

    // One returned input credit per result, exactly one cycle later
    a_credit_return: assert property (@(posedge clk) disable iff (rst)
        in_credit == $past(res_valid))
        else $error("in_credit does not follow res_valid by one cycle");

endmodule

bind result_queue byte_engine_props #(
    .IN_CREDITS (IN_CREDITS),
    .FILL_W     (fill_w),
    .CNT_W      (cnt_w)
) u_props (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .in_credit (in_credit),
    .fill      (fill),
    .out_cnt   (out_cnt)
);

/* bench/byte_engine_tb.sv */
// Byte engine testbench driving a stimulus table against a register model with credit checks
`timescale 1ns/1ps

module byte_engine_tb;

    localparam int num_entries   = 16;
    localparam int timeout_limit = 200 * num_entries;

    logic                            clk;
    logic                            rst;
    logic                            beat_valid;
    logic [engine_pkg::beat_w-1:0]   beat;
    logic                            in_credit;
    logic                            res_valid;
    logic [engine_pkg::result_w-1:0] res;
    logic                            out_credit;
    logic                            hold_credits;

    logic [engine_pkg::word_w-1:0]   word_tab [num_entries];
    logic [engine_pkg::result_w-1:0] exp_tab [num_entries];
    logic [engine_pkg::data_w-1:0]   model_regs [16];
    int entry_count, words_started, words_done, results_seen, credits_returned, credits_given;
    int cycle_count, value_errors, protocol_errors, backpressure_errors;
    int unsigned gap_rand, credit_rand;

    byte_engine_top dut (.*);

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 1103515245 + 12345;
    endfunction

    // Encodes one instruction and steps the register model to get its result
    task automatic add_entry(input engine_pkg::opcode_e op, input logic [3:0] dst,
                             input logic [3:0] src_a, input logic [3:0] src_b,
                             input logic [15:0] imm);
        logic        imm_form;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] v;
        imm_form = (op == engine_pkg::ADDI) || (op == engine_pkg::XORI)
                   || (op == engine_pkg::LDI);
        a = model_regs[src_a];
        b = imm_form ? imm : model_regs[src_b];
        case (op)
            engine_pkg::ADD, engine_pkg::ADDI: v = a + b;
            engine_pkg::SUB:                   v = a - b;
            engine_pkg::AND:                   v = a & b;
            engine_pkg::OR:                    v = a | b;
            engine_pkg::XOR, engine_pkg::XORI: v = a ^ b;
            engine_pkg::SHL:                   v = a << b[3:0];
            engine_pkg::SHR:                   v = a >> b[3:0];
            engine_pkg::LDI:                   v = imm;
            default:                           v = a;
        endcase
        model_regs[dst] = v;
        word_tab[entry_count] = imm_form ? {op, dst, src_a, imm, 4'h0}
                                         : {op, dst, src_a, src_b, 16'h0};
        exp_tab[entry_count] = {dst, v};
        entry_count++;
    endtask

    // Four beats, top byte first, random gaps; the credit is spent on the first beat
    task automatic send_word(input logic [31:0] w);
        int gap;
        int b;
        while (words_started - credits_returned >= engine_pkg::in_credits_def) begin
            @(posedge clk);
            #2;
        end
        for (b = 0; b < 4; b++) begin
            gap_rand = lcg_next(gap_rand);
            gap = (gap_rand >> 16) % 3;
            beat_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            if (b == 0) begin
                words_started++;
            end
            beat_valid = 1'b1;
            beat = w[31 - 8 * b -: 8];
            @(posedge clk);
            #2;
        end
        beat_valid = 1'b0;
        words_done++;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Outputs sampled on the falling edge
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("Run stopped after %0d cycles with %0d of %0d results received",
                     cycle_count, results_seen, num_entries);
            $display("Test failures found");
            $finish;
        end else begin
            if (res_valid === 1'b1) begin
                if (results_seen >= words_done) begin
                    $display("Result at %0t with no finished instruction to answer", $time);
                    protocol_errors++;
                end else begin
                    if (res !== exp_tab[results_seen]) begin
                        $display("FAILED t=%0t res: expected %h, got %h", $time,
                                 exp_tab[results_seen], res);
                        value_errors++;
                    end
                    results_seen++;
                end
            end
            if (in_credit === 1'b1) begin
                if (credits_returned >= results_seen) begin
                    $display("in_credit pulse at %0t with no result to pay for", $time);
                    protocol_errors++;
                end else begin
                    credits_returned++;
                end
            end
        end
    end

    // Consumer returns one output credit per result after a random delay
    initial begin
        out_credit = 1'b0;
        credit_rand = 64927;
        forever begin
            @(posedge clk);
            #2;
            out_credit = 1'b0;
            if (!hold_credits && credits_given < results_seen) begin
                credit_rand = lcg_next(credit_rand);
                repeat ((credit_rand >> 16) % 4) begin
                    @(posedge clk);
                    #2;
                end
                out_credit = 1'b1;
                credits_given++;
            end
        end
    end

    initial begin
        int i;
        rst = 1'b1;
        beat_valid = 1'b0;
        beat = '0;
        hold_credits = 1'b1;
        gap_rand = 64927;
        // Model registers start at zero like the design after reset
        for (i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        // Every byte of the first word differs, so any packing slip shows in the result
        add_entry(engine_pkg::LDI,  4'd1,  4'd15, 4'd0,  16'hA5C3);
        add_entry(engine_pkg::LDI,  4'd2,  4'd0,  4'd0,  16'h0F0F);
        add_entry(engine_pkg::ADD,  4'd3,  4'd1,  4'd2,  16'h0000);
        add_entry(engine_pkg::SUB,  4'd4,  4'd2,  4'd1,  16'h0000);
        add_entry(engine_pkg::AND,  4'd5,  4'd1,  4'd2,  16'h0000);
        add_entry(engine_pkg::OR,   4'd6,  4'd1,  4'd2,  16'h0000);
        add_entry(engine_pkg::XOR,  4'd7,  4'd1,  4'd2,  16'h0000);
        add_entry(engine_pkg::ADDI, 4'd8,  4'd3,  4'd0,  16'hFFFF);
        add_entry(engine_pkg::XORI, 4'd9,  4'd1,  4'd0,  16'h5A5A);
        add_entry(engine_pkg::LDI,  4'd10, 4'd0,  4'd0,  16'h0015);
        add_entry(engine_pkg::SHL,  4'd11, 4'd1,  4'd10, 16'h0000);
        add_entry(engine_pkg::SHR,  4'd12, 4'd1,  4'd10, 16'h0000);
        add_entry(engine_pkg::SUB,  4'd15, 4'd0,  4'd1,  16'h0000);
        add_entry(engine_pkg::ADD,  4'd1,  4'd1,  4'd1,  16'h0000);
        add_entry(engine_pkg::ADDI, 4'd0,  4'd15, 4'd0,  16'h0001);
        add_entry(engine_pkg::SHR,  4'd2,  4'd12, 4'd2,  16'h0000);
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        fork
            begin
                for (i = 0; i < num_entries; i++) begin
                    send_word(word_tab[i]);
                end
            end
            begin
                // Credits withheld until the design has spent all of its own
                wait (results_seen >= engine_pkg::out_credits_def);
                repeat (40) @(posedge clk);
                if (results_seen > engine_pkg::out_credits_def) begin
                    $display("%0d results appeared with only %0d output credits",
                             results_seen, engine_pkg::out_credits_def);
                    backpressure_errors++;
                end
                hold_credits = 1'b0;
            end
        join
        wait (results_seen == num_entries && credits_returned == num_entries);
        repeat (20) @(posedge clk);
        $display("Errors: %0d value, %0d protocol, %0d back-pressure; %0d results, %0d credits",
                 value_errors, protocol_errors, backpressure_errors, results_seen,
                 credits_returned);
        if (value_errors + protocol_errors + backpressure_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* byte_engine_top.f */
common/engine_pkg.sv
common/decoded_if.sv
hdl/byte_packer.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/result_queue.sv
hdl/byte_engine_top.sv
bench/byte_engine_props.sv
bench/byte_engine_tb.sv

/* common/decoded_if.sv */
// Decoded operation bus carrying one operation from decode to execute
`timescale 1ns/1ps

interface decoded_if;

    logic                                 valid;
    engine_pkg::opcode_e                  op;
    logic [engine_pkg::reg_idx_w-1:0]     dst;
    logic [engine_pkg::reg_idx_w-1:0]     src_a;
    logic [engine_pkg::reg_idx_w-1:0]     src_b;
    logic [engine_pkg::data_w-1:0]        imm;
    // Operand B comes from imm instead of the register file
    logic                                 use_imm;

    modport producer (
        output valid, op, dst, src_a, src_b, imm, use_imm
    );

    modport consumer (
        input valid, op, dst, src_a, src_b, imm, use_imm
    );

endinterface

/* common/engine_pkg.sv */
// Engine package with widths, opcodes, instruction formats and credit depths
package engine_pkg;

    parameter int beat_w    = 8;
    parameter int word_w    = 32;
    parameter int data_w    = 16;
    parameter int reg_idx_w = 4;
    parameter int result_w  = reg_idx_w + data_w;

    // Default credit depths, overridable at the top level
    parameter int in_credits_def  = 4;
    parameter int out_credits_def = 4;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        ADDI = 4'd5,
        XORI = 4'd6,
        LDI  = 4'd7,
        SHL  = 4'd8,
        SHR  = 4'd9
    } opcode_e;

    // Register form, two register sources
    typedef struct packed {
        opcode_e                opcode;
        logic [reg_idx_w-1:0]   dst;
        logic [reg_idx_w-1:0]   src_a;
        logic [reg_idx_w-1:0]   src_b;
        logic [15:0]            unused;
    } rform_s;

    // Immediate form, one register source and a 16-bit constant
    typedef struct packed {
        opcode_e                opcode;
        logic [reg_idx_w-1:0]   dst;
        logic [reg_idx_w-1:0]   src_a;
        logic [data_w-1:0]      imm;
        logic [3:0]             unused;
    } iform_s;

    typedef union packed {
        rform_s r;
        iform_s i;
    } instr_word_u;

endpackage

/* hdl/alu_execute.sv */
// Execute stage with a 16-entry register file and ALU, one operation per cycle
`timescale 1ns/1ps

module alu_execute (
    input  logic                            clk,
    input  logic                            rst,
    decoded_if.consumer                     dec,
    output logic                            exec_valid,
    output logic [engine_pkg::result_w-1:0] exec_result
);

    localparam int num_regs = 1 << engine_pkg::reg_idx_w;

    logic [engine_pkg::data_w-1:0] regs [num_regs];
    logic [engine_pkg::data_w-1:0] opnd_a;
    logic [engine_pkg::data_w-1:0] opnd_b;
    logic [engine_pkg::data_w-1:0] alu_out;

    assign opnd_a = regs[dec.src_a];
    assign opnd_b = dec.use_imm ? dec.imm : regs[dec.src_b];

    // All arithmetic wraps at the register width
    always_comb begin
        case (dec.op)
            engine_pkg::ADD,
            engine_pkg::ADDI: alu_out = opnd_a + opnd_b;
            engine_pkg::SUB:  alu_out = opnd_a - opnd_b;
            engine_pkg::AND:  alu_out = opnd_a & opnd_b;
            engine_pkg::OR:   alu_out = opnd_a | opnd_b;
            engine_pkg::XOR,
            engine_pkg::XORI: alu_out = opnd_a ^ opnd_b;
            // Source A is ignored here
            engine_pkg::LDI:  alu_out = opnd_b;
            engine_pkg::SHL:  alu_out = opnd_a << opnd_b[3:0];
            engine_pkg::SHR:  alu_out = opnd_a >> opnd_b[3:0];
            // Undefined opcodes copy source A
            default:          alu_out = opnd_a;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= dec.valid;
            if (dec.valid) begin
                regs[dec.dst] <= alu_out;
            end
        end
    end

    // Result word is destination index over new value
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            exec_result <= {dec.dst, alu_out};
        end
    end

endmodule

/* hdl/byte_engine_top.sv */
// Byte-fed instruction engine top connecting packer, decode, execute and result queue
`timescale 1ns/1ps

module byte_engine_top #(
    parameter int IN_CREDITS  = engine_pkg::in_credits_def,
    parameter int OUT_CREDITS = engine_pkg::out_credits_def
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            beat_valid,
    input  logic [engine_pkg::beat_w-1:0]   beat,
    output logic                            in_credit,
    output logic                            res_valid,
    output logic [engine_pkg::result_w-1:0] res,
    input  logic                            out_credit
);

    logic                            word_valid;
    logic [engine_pkg::word_w-1:0]   word;
    logic                            exec_valid;
    logic [engine_pkg::result_w-1:0] exec_result;

    decoded_if dec_bus ();

    byte_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (beat_valid),
        .beat       (beat),
        .word_valid (word_valid),
        .word       (word)
    );

    instr_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .word_valid (word_valid),
        .word       (word),
        .dec        (dec_bus.producer)
    );

    alu_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec_bus.consumer),
        .exec_valid  (exec_valid),
        .exec_result (exec_result)
    );

    result_queue #(
        .IN_CREDITS  (IN_CREDITS),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_queue (
        .clk         (clk),
        .rst         (rst),
        .exec_valid  (exec_valid),
        .exec_result (exec_result),
        .res_valid   (res_valid),
        .res         (res),
        .out_credit  (out_credit),
        .in_credit   (in_credit)
    );

endmodule

/* hdl/byte_packer.sv */
// Byte packer building 32-bit words from 8-bit beats over a three-stage pipeline
`timescale 1ns/1ps

module byte_packer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          beat_valid,
    input  logic [engine_pkg::beat_w-1:0] beat,
    output logic                          word_valid,
    output logic [engine_pkg::word_w-1:0] word
);

    localparam int beats_per_word = engine_pkg::word_w / engine_pkg::beat_w;
    localparam int cnt_w          = $clog2(beats_per_word);

    logic [cnt_w-1:0]                beat_cnt;
    logic [engine_pkg::word_w-1:0]   shift_buf;
    logic [engine_pkg::word_w-1:0]   cut_buf;
    logic [engine_pkg::word_w-1:0]   out_buf;
    logic                            last_s1;
    logic                            last_s2;
    logic                            last_s3;

    // Beat count and word-complete flags down the pipe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt   <= '0;
            last_s1    <= 1'b0;
            last_s2    <= 1'b0;
            last_s3    <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            last_s1 <= beat_valid && (beat_cnt == cnt_w'(beats_per_word - 1));
            if (beat_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            last_s2    <= last_s1;
            last_s3    <= last_s2;
            word_valid <= last_s3;
        end
    end

    // Data path, first beat ends up in the top byte
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            shift_buf <= {shift_buf[engine_pkg::word_w-engine_pkg::beat_w-1:0], beat};
        end
        // Pipeline cut
        cut_buf <= shift_buf;
        if (last_s2) begin
            out_buf <= cut_buf;
        end
        word <= out_buf;
    end

endmodule

/* hdl/instr_decode.sv */
// Instruction decoder splitting a packed word into operation fields by format
`timescale 1ns/1ps

module instr_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          word_valid,
    input  logic [engine_pkg::word_w-1:0] word,
    decoded_if.producer                   dec
);

    engine_pkg::instr_word_u   instr;
    logic                      is_imm;

    assign instr = word;

    // Opcode sits in the same place in both forms
    always_comb begin
        case (instr.r.opcode)
            engine_pkg::ADDI,
            engine_pkg::XORI,
            engine_pkg::LDI: is_imm = 1'b1;
            default:         is_imm = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= word_valid;
        end
    end

    // Field registers, only loaded with a new word
    always_ff @(posedge clk) begin
        if (word_valid) begin
            dec.op      <= instr.r.opcode;
            dec.use_imm <= is_imm;
            // Destination and source A share their place in both forms
            dec.dst     <= instr.r.dst;
            dec.src_a   <= instr.r.src_a;
            if (is_imm) begin
                dec.src_b <= '0;
                dec.imm   <= instr.i.imm;
            end else begin
                dec.src_b <= instr.r.src_b;
                dec.imm   <= '0;
            end
        end
    end

endmodule

/* hdl/result_queue.sv */
// Result FIFO gated by output credits, returning one input credit per result
`timescale 1ns/1ps

module result_queue #(
    parameter int IN_CREDITS  = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            exec_valid,
    input  logic [engine_pkg::result_w-1:0] exec_result,
    output logic                            res_valid,
    output logic [engine_pkg::result_w-1:0] res,
    input  logic                            out_credit,
    output logic                            in_credit
);

    localparam int ptr_w  = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int fill_w = $clog2(IN_CREDITS + 1);
    localparam int cnt_w  = $clog2(OUT_CREDITS + 1);

    logic [engine_pkg::result_w-1:0] mem [IN_CREDITS];
    logic [ptr_w-1:0]                wr_ptr;
    logic [ptr_w-1:0]                rd_ptr;
    logic [fill_w-1:0]               fill;
    logic [cnt_w-1:0]                out_cnt;
    logic                            pop;

    // Input credits keep the queue from overflowing, so push is never refused
    assign pop = (fill != '0) && (out_cnt != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            out_cnt   <= cnt_w'(OUT_CREDITS);
            res_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            if (exec_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill    <= fill + fill_w'(exec_valid) - fill_w'(pop);
            out_cnt <= out_cnt + cnt_w'(out_credit) - cnt_w'(pop);
            res_valid <= pop;
            // Credit goes back one cycle after the result leaves
            in_credit <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            mem[wr_ptr] <= exec_result;
        end
        if (pop) begin
            res <= mem[rd_ptr];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module byte_engine_tb \
    -f byte_engine_top.f -o byte_engine_sim
./obj_dir/byte_engine_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
